// File: agen_macros.svh
/*
 * width and count definitions for the address generation stage
 */
`ifndef AGEN_MACROS_SVH
`define AGEN_MACROS_SVH

// register, operand and linear address width
`define AGEN_DATA_W 32

// segment register width
`define AGEN_SEG_W 16

// general registers eax..edi
`define AGEN_NUM_GPR 8

// es, cs, ss, ds, fs, gs
`define AGEN_NUM_SEG 6

// real-mode style segment base shift
`define AGEN_SEG_SHIFT 4

`endif

// File: agen_pkg.sv
/*
 * operand source, operand size and segment index encodings
 * general register and segment register file types
 */
`include "agen_macros.svh"

package agen_pkg;

    // mm, modrm and sys have no datapath in this stage
    typedef enum logic [2:0] {
        SRC_NONE  = 3'd0,
        SRC_REG   = 3'd1,
        SRC_SEG   = 3'd2,
        SRC_MM    = 3'd3,
        SRC_MODRM = 3'd4,
        SRC_IMM   = 3'd5,
        SRC_MEM   = 3'd6,
        SRC_SYS   = 3'd7
    } op_src_t;

    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3
    } op_size_t;

    // 6 and 7 are unused and read as zero
    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_idx_t;

    // eax, ecx, edx, ebx, esp, ebp, esi, edi
    typedef logic [`AGEN_NUM_GPR-1:0][`AGEN_DATA_W-1:0] gpr_file_t;

    typedef logic [`AGEN_NUM_SEG-1:0][`AGEN_SEG_W-1:0] seg_file_t;

endpackage

// File: gpr_size_select.sv
/*
 * size-adjusted views of the eight general registers
 * byte, word and dword reads, zero-extended
 */
`timescale 1ns/1ns
`include "agen_macros.svh"

module gpr_size_select (
    input  agen_pkg::op_size_t  size,
    input  agen_pkg::gpr_file_t gpr,
    output agen_pkg::gpr_file_t sized
);

    import agen_pkg::*;

    // x86 byte registers 4..7 are the high halves of the first four
    localparam int NUM_BYTE_LO = 4;

    always_comb begin
        sized = '0;
        for (int i = 0; i < `AGEN_NUM_GPR; i++) begin
            case (size)
                SIZE_BYTE: begin
                    // al..bl, then ah..bh from bits 15:8 of eax..ebx
                    if (i < NUM_BYTE_LO) begin
                        sized[i][7:0] = gpr[i][7:0];
                    end else begin
                        sized[i][7:0] = gpr[i % NUM_BYTE_LO][15:8];
                    end
                end
                SIZE_WORD: begin
                    sized[i][15:0] = gpr[i][15:0];
                end
                SIZE_DWORD: begin
                    sized[i] = gpr[i];
                end
                default: begin
                    // undefined size reads as zero
                    sized[i] = '0;
                end
            endcase
        end
    end

endmodule

// File: operand_select.sv
/*
 * one operand mux: register, segment, immediate or string address
 * plus the address, register and segment flags for the memory stage
 */
`timescale 1ns/1ns
`include "agen_macros.svh"

module operand_select #(
    parameter bit IS_DEST = 1'b0
) (
    input  agen_pkg::op_src_t        src,
    input  logic [2:0]               reg_idx,
    input  agen_pkg::op_size_t       size,
    input  agen_pkg::gpr_file_t      sized,
    input  agen_pkg::gpr_file_t      gpr,
    input  agen_pkg::seg_file_t      seg,
    input  logic [`AGEN_DATA_W-1:0]  imm,
    input  agen_pkg::seg_idx_t       seg_override,
    input  logic                     seg_override_valid,
    output logic [`AGEN_DATA_W-1:0]  operand,
    output logic                     is_address,
    output logic                     is_reg,
    output logic                     is_segment
);

    import agen_pkg::*;

    localparam int ESI_IDX = 6;
    localparam int EDI_IDX = 7;

    seg_idx_t                addr_seg_idx;
    logic [`AGEN_SEG_W-1:0]  addr_seg;
    logic [`AGEN_SEG_W-1:0]  reg_seg;
    logic [`AGEN_DATA_W-1:0] index;
    logic [`AGEN_DATA_W-1:0] mem_addr;

    function automatic logic [`AGEN_SEG_W-1:0] seg_read(input seg_file_t file,
                                                        input logic [2:0] idx);
        seg_read = '0;
        if (idx < `AGEN_NUM_SEG) begin
            seg_read = file[idx];
        end
    endfunction

    // destination strings are always es:edi, sources ds:esi unless overridden
    always_comb begin
        if (IS_DEST) begin
            addr_seg_idx = SEG_ES;
        end else if (seg_override_valid) begin
            addr_seg_idx = seg_override;
        end else begin
            addr_seg_idx = SEG_DS;
        end
    end

    assign addr_seg = seg_read(seg, addr_seg_idx);
    assign reg_seg  = seg_read(seg, reg_idx);
    assign index    = IS_DEST ? gpr[EDI_IDX] : gpr[ESI_IDX];

    assign mem_addr = ({{(`AGEN_DATA_W-`AGEN_SEG_W){1'b0}}, addr_seg} << `AGEN_SEG_SHIFT)
                    + index;

    always_comb begin
        case (src)
            SRC_REG: operand = sized[reg_idx];
            SRC_SEG: operand = {{(`AGEN_DATA_W-`AGEN_SEG_W){1'b0}}, reg_seg};
            SRC_IMM: operand = imm;
            SRC_MEM: operand = mem_addr;
            default: operand = '0;
        endcase
    end

    assign is_address = (src == SRC_MEM);
    assign is_reg     = (src == SRC_REG);
    assign is_segment = (src == SRC_SEG);

    // decode never hands this stage an mmx, mod r/m or system operand
    always_comb begin
        assert final (!(src inside {SRC_MM, SRC_MODRM, SRC_SYS}))
            else $error("operand_select: unsupported source %0d", src);
    end

    // size selector and this mux must agree on the operand size
    always_comb begin
        assert final (src != SRC_REG || size == SIZE_DWORD
                      || sized[reg_idx][`AGEN_DATA_W-1:16] == '0)
            else $error("operand_select: register view wider than size %0d", size);
    end

endmodule

// File: agen_pipestage.sv
/*
 * one-entry registered valid/ready pipe stage with flush
 */
`timescale 1ns/1ns

module agen_pipestage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic load;

    // empty, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // stalled item holds until taken or flushed
    property p_stall_hold;
        @(posedge clk) disable iff (!arst_n)
            (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data));
    endproperty

    a_stall_hold: assert property (p_stall_hold)
        else $error("agen_pipestage: output changed while stalled");

endmodule

// File: address_generation_top.sv
/*
 * operand address generation stage
 * size selector, op0 and op1 selectors, stack pop override, pipe register
 */
`timescale 1ns/1ns
`include "agen_macros.svh"

module address_generation_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     r_valid,
    output logic                     r_ready,
    input  agen_pkg::op_size_t       r_size,
    input  agen_pkg::op_src_t        r_op0,
    input  agen_pkg::op_src_t        r_op1,
    input  logic [2:0]               r_op0_reg,
    input  logic [2:0]               r_op1_reg,
    input  logic [`AGEN_DATA_W-1:0]  r_imm,
    input  agen_pkg::seg_idx_t       r_seg_override,
    input  logic                     r_seg_override_valid,
    input  logic [1:0]               r_stack_op,
    input  logic [`AGEN_DATA_W-1:0]  r_stack_address,
    input  agen_pkg::gpr_file_t      r_gpr,
    input  agen_pkg::seg_file_t      r_seg,
    input  logic [`AGEN_DATA_W-1:0]  r_pc,
    input  logic [15:0]              r_opcode,
    output logic                     a_valid,
    input  logic                     a_ready,
    output agen_pkg::op_size_t       a_size,
    output logic [`AGEN_DATA_W-1:0]  a_op0,
    output logic [`AGEN_DATA_W-1:0]  a_op1,
    output logic                     a_op0_is_address,
    output logic                     a_op0_is_reg,
    output logic                     a_op0_is_segment,
    output logic                     a_op1_is_address,
    output logic                     a_op1_is_reg,
    output logic [1:0]               a_stack_op,
    output logic [`AGEN_DATA_W-1:0]  a_pc,
    output logic [15:0]              a_opcode
);

    import agen_pkg::*;

    localparam int PIPE_W = $bits(op_size_t) + 3 * `AGEN_DATA_W + 5 + 2 + 16;

    gpr_file_t               sized;
    logic [`AGEN_DATA_W-1:0] op0_value;
    logic                    op0_is_address;
    logic                    op0_is_reg;
    logic                    op0_is_segment;
    logic [`AGEN_DATA_W-1:0] op1_sel_value;
    logic                    op1_sel_is_address;
    logic                    op1_is_reg;
    logic [`AGEN_DATA_W-1:0] op1_value;
    logic                    op1_is_address;
    logic [2:0]              size_q;
    logic [PIPE_W-1:0]       pipe_in;
    logic [PIPE_W-1:0]       pipe_out;

    gpr_size_select u_size_sel (
        .size  (r_size),
        .gpr   (r_gpr),
        .sized (sized)
    );

    operand_select #(.IS_DEST(1'b1)) u_op0_sel (
        .src                (r_op0),
        .reg_idx            (r_op0_reg),
        .size               (r_size),
        .sized              (sized),
        .gpr                (r_gpr),
        .seg                (r_seg),
        .imm                (r_imm),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .operand            (op0_value),
        .is_address         (op0_is_address),
        .is_reg             (op0_is_reg),
        .is_segment         (op0_is_segment)
    );

    operand_select #(.IS_DEST(1'b0)) u_op1_sel (
        .src                (r_op1),
        .reg_idx            (r_op1_reg),
        .size               (r_size),
        .sized              (sized),
        .gpr                (r_gpr),
        .seg                (r_seg),
        .imm                (r_imm),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .operand            (op1_sel_value),
        .is_address         (op1_sel_is_address),
        .is_reg             (op1_is_reg),
        .is_segment         ()
    );

    // pop reads op1 from the stack
    assign op1_value      = r_stack_op[1] ? r_stack_address : op1_sel_value;
    assign op1_is_address = r_stack_op[1] | op1_sel_is_address;

    assign pipe_in = {r_size, op0_value, op1_value,
                      op0_is_address, op0_is_reg, op0_is_segment,
                      op1_is_address, op1_is_reg,
                      r_stack_op, r_pc, r_opcode};

    agen_pipestage #(.WIDTH(PIPE_W)) u_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (pipe_in),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (pipe_out)
    );

    assign {size_q, a_op0, a_op1,
            a_op0_is_address, a_op0_is_reg, a_op0_is_segment,
            a_op1_is_address, a_op1_is_reg,
            a_stack_op, a_pc, a_opcode} = pipe_out;

    assign a_size = op_size_t'(size_q);

endmodule

// File: tb_clock_gen.sv
/*
 * testbench clock and active-low reset
 */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release between edges, away from the flop updates
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: tb_address_generation.sv
/*
 * testbench for the address generation stage
 * random stimulus, reference model and queue, output assertions, watchdog
 */
`timescale 1ns/1ns
`include "agen_macros.svh"

module tb_address_generation;

    import agen_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_TXN      = 24 + 16 + 16 + 16 + 40 + 3 * 5;
    localparam int KIND_REG     = 0;
    localparam int KIND_SEG     = 1;
    localparam int KIND_MEM     = 2;
    localparam int KIND_POP     = 3;
    localparam int KIND_MIX     = 4;
    localparam int SINK_READY   = 0;
    localparam int SINK_RANDOM  = 1;
    localparam int SINK_STALL   = 2;
    localparam op_src_t SUPPORTED_SRC[5] = '{SRC_NONE, SRC_REG, SRC_SEG, SRC_IMM, SRC_MEM};

    typedef struct packed {
        op_size_t                size;
        logic [`AGEN_DATA_W-1:0] op0;
        logic [`AGEN_DATA_W-1:0] op1;
        logic [4:0]              flags;
        logic [1:0]              stack_op;
        logic [`AGEN_DATA_W-1:0] pc;
        logic [15:0]             opcode;
    } item_t;

    logic                    clk, arst_n, flush;
    logic                    r_valid, r_ready, r_seg_override_valid;
    op_size_t                r_size, a_size;
    op_src_t                 r_op0, r_op1;
    logic [2:0]              r_op0_reg, r_op1_reg;
    seg_idx_t                r_seg_override;
    logic [1:0]              r_stack_op, a_stack_op;
    logic [`AGEN_DATA_W-1:0] r_imm, r_stack_address, r_pc, a_op0, a_op1, a_pc;
    logic [15:0]             r_opcode, a_opcode;
    gpr_file_t               r_gpr;
    seg_file_t               r_seg;
    logic                    a_valid, a_ready, a_op0_is_address, a_op0_is_reg;
    logic                    a_op0_is_segment, a_op1_is_address, a_op1_is_reg;

    item_t exp_q[$];
    item_t exp_front, out_item;
    logic  exp_valid, accepted_q;
    int    ready_mode, txn_count;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    address_generation_top u_address_generation_top (.*);

    assign out_item = {a_size, a_op0, a_op1, a_op0_is_address, a_op0_is_reg, a_op0_is_segment,
                       a_op1_is_address, a_op1_is_reg, a_stack_op, a_pc, a_opcode};

    function automatic logic [`AGEN_DATA_W-1:0] zext(input logic [15:0] v);
        return {{(`AGEN_DATA_W-16){1'b0}}, v};
    endfunction

    // byte indices 4..7 are ah, ch, dh, bh
    function automatic logic [`AGEN_DATA_W-1:0] reg_view(input logic [2:0] idx);
        case (r_size)
            SIZE_BYTE:  return idx[2] ? zext({8'd0, r_gpr[idx[1:0]][15:8]})
                                      : zext({8'd0, r_gpr[idx][7:0]});
            SIZE_WORD:  return zext(r_gpr[idx][15:0]);
            SIZE_DWORD: return r_gpr[idx];
            default:    return '0;
        endcase
    endfunction

    function automatic logic [`AGEN_DATA_W-1:0] seg_value(input logic [2:0] idx);
        return (idx < `AGEN_NUM_SEG) ? zext(r_seg[idx]) : '0;
    endfunction

    function automatic logic [`AGEN_DATA_W-1:0] operand_value(input op_src_t src,
                                                            input logic [2:0] idx,
                                                            input logic dest);
        logic [2:0] str_seg;
        if (dest) begin
            str_seg = SEG_ES;
        end else if (r_seg_override_valid) begin
            str_seg = r_seg_override;
        end else begin
            str_seg = SEG_DS;
        end
        case (src)
            SRC_REG: return reg_view(idx);
            SRC_SEG: return seg_value(idx);
            SRC_IMM: return r_imm;
            // es:edi for op0, ds or override with esi for op1
            SRC_MEM: return (seg_value(str_seg) << `AGEN_SEG_SHIFT) + r_gpr[dest ? 7 : 6];
            default: return '0;
        endcase
    endfunction

    function automatic item_t reference_item();
        item_t it;
        it.size     = r_size;
        it.op0      = operand_value(r_op0, r_op0_reg, 1'b1);
        it.op1      = r_stack_op[1] ? r_stack_address : operand_value(r_op1, r_op1_reg, 1'b0);
        it.flags    = {r_op0 == SRC_MEM, r_op0 == SRC_REG, r_op0 == SRC_SEG,
                       r_op1 == SRC_MEM || r_stack_op[1], r_op1 == SRC_REG};
        it.stack_op = r_stack_op;
        it.pc       = r_pc;
        it.opcode   = r_opcode;
        return it;
    endfunction

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_value_mismatch(input string name, input logic [31:0] exp_v,
                                         input logic [31:0] act_v);
        $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp_v, act_v);
        stop_with_failure();
    endtask

    task automatic report_output_mismatch(input logic has_exp, input item_t exp_it,
                                          input item_t act_it);
        if (!has_exp) begin
            $display("an item left the stage while none was expected");
            stop_with_failure();
        end else if (exp_it.op0 != act_it.op0) begin
            report_value_mismatch("a_op0", exp_it.op0, act_it.op0);
        end else if (exp_it.op1 != act_it.op1) begin
            report_value_mismatch("a_op1", exp_it.op1, act_it.op1);
        end else if (exp_it.flags != act_it.flags) begin
            report_value_mismatch("a_op0/a_op1 flags", 32'(exp_it.flags), 32'(act_it.flags));
        end else if (exp_it.pc != act_it.pc) begin
            report_value_mismatch("a_pc", exp_it.pc, act_it.pc);
        end else if (exp_it.size != act_it.size) begin
            report_value_mismatch("a_size", 32'(exp_it.size), 32'(act_it.size));
        end else if (exp_it.stack_op != act_it.stack_op) begin
            report_value_mismatch("a_stack_op", 32'(exp_it.stack_op), 32'(act_it.stack_op));
        end else begin
            report_value_mismatch("a_opcode", 32'(exp_it.opcode), 32'(act_it.opcode));
        end
    endtask

    // expected queue follows the handshake; flush drops everything in flight
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            exp_valid  <= 1'b0;
            exp_front  <= '0;
            accepted_q <= 1'b0;
        end else begin
            if (flush) begin
                exp_q.delete();
            end else begin
                if (a_valid && a_ready && exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                if (r_valid && r_ready) begin
                    exp_q.push_back(reference_item());
                end
            end
            accepted_q <= r_valid && r_ready && !flush;
            exp_valid  <= (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                exp_front <= exp_q[0];
            end
        end
    end

    a_out_match: assert property (@(posedge clk) disable iff (!arst_n)
        (a_valid && a_ready && !flush) |-> (exp_valid && out_item == exp_front))
        else report_output_mismatch($sampled(exp_valid), $sampled(exp_front),
                                    $sampled(out_item));

    a_ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
        r_ready == (!a_valid || a_ready))
        else report_value_mismatch("r_ready", 32'($sampled(!a_valid || a_ready)),
                                   32'($sampled(r_ready)));

    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (a_valid && !a_ready && !flush) |=> (a_valid && $stable(out_item)))
        else begin
            $display("stalled output changed before the sink took it");
            stop_with_failure();
        end

    a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !a_valid)
        else report_value_mismatch("a_valid", 32'd0, 32'($sampled(a_valid)));

    task automatic drive_ready();
        if (ready_mode == SINK_RANDOM) begin
            a_ready = 1'($urandom());
        end else begin
            a_ready = (ready_mode == SINK_READY);
        end
    endtask

    task automatic build_item(input int kind, input int n);
        for (int i = 0; i < `AGEN_NUM_GPR; i++) begin
            r_gpr[i] = $urandom();
        end
        for (int i = 0; i < `AGEN_NUM_SEG; i++) begin
            r_seg[i] = 16'($urandom());
        end
        r_size               = op_size_t'($urandom_range(3, 1));
        r_op0                = SUPPORTED_SRC[$urandom_range(4, 0)];
        r_op1                = SUPPORTED_SRC[$urandom_range(4, 0)];
        r_op0_reg            = 3'($urandom());
        r_op1_reg            = 3'($urandom());
        r_imm                = $urandom();
        r_seg_override       = seg_idx_t'($urandom_range(7, 0));
        r_seg_override_valid = 1'($urandom());
        r_stack_op           = {1'b0, 1'($urandom())};
        r_stack_address      = $urandom();
        r_pc                 = 32'(txn_count);
        r_opcode             = 16'($urandom());
        txn_count++;
        case (kind)
            KIND_REG: begin
                // byte, word, dword in turn, all eight indices each
                r_size    = op_size_t'(n / 8 + 1);
                r_op0     = SRC_REG;
                r_op1     = SRC_REG;
                r_op0_reg = 3'(n);
                r_op1_reg = 3'(n + 3);
            end
            KIND_SEG: begin
                r_op0     = SRC_SEG;
                r_op0_reg = 3'(n);
                r_op1     = n[0] ? SRC_IMM : SRC_SEG;
            end
            KIND_MEM: begin
                r_op0                = SRC_MEM;
                r_op1                = SRC_MEM;
                r_seg_override_valid = n[0];
            end
            KIND_POP: begin
                r_stack_op[1] = 1'b1;
            end
            default: begin
                r_stack_op = 2'($urandom());
            end
        endcase
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_item(input int kind, input int n);
        build_item(kind, n);
        r_valid = 1'b1;
        do begin
            @(negedge clk);
            drive_ready();
        end while (!accepted_q);
        r_valid = 1'b0;
    endtask

    task automatic flush_round(input int k);
        ready_mode = SINK_READY;
        a_ready    = 1'b1;
        repeat (2) @(negedge clk);
        // park one item in the stage, then flush it
        ready_mode = SINK_STALL;
        a_ready    = 1'b0;
        send_item(KIND_MIX, k);
        repeat (2) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        ready_mode = SINK_READY;
        a_ready    = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_item(KIND_MIX, i);
        end
    endtask

    initial begin
        void'($urandom(32'h1d57));
        flush      = 1'b0;
        r_valid    = 1'b0;
        a_ready    = 1'b1;
        ready_mode = SINK_READY;
        txn_count  = 0;
        build_item(KIND_MIX, 0);
        txn_count  = 0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        for (int n = 0; n < 24; n++) begin
            send_item(KIND_REG, n);
        end
        for (int n = 0; n < 16; n++) begin
            send_item(KIND_SEG, n);
        end
        for (int n = 0; n < 16; n++) begin
            send_item(KIND_MEM, n);
        end
        for (int n = 0; n < 16; n++) begin
            send_item(KIND_POP, n);
        end
        ready_mode = SINK_RANDOM;
        for (int n = 0; n < 40; n++) begin
            send_item(KIND_MIX, n);
        end
        for (int k = 0; k < 3; k++) begin
            flush_round(k);
        end
        ready_mode = SINK_READY;
        a_ready    = 1'b1;
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected items never left the stage", exp_q.size());
            stop_with_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    initial begin
        #((20 * NUM_TXN + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        stop_with_failure();
    end

endmodule

// File: sim.f
+incdir+.
agen_pkg.sv
gpr_size_select.sv
operand_select.sv
agen_pipestage.sv
address_generation_top.sv
tb_clock_gen.sv
tb_address_generation.sv

// File: Bender.yml
package:
  name: address_generation

export_include_dirs:
  - .

sources:
  - agen_pkg.sv
  - gpr_size_select.sv
  - operand_select.sv
  - agen_pipestage.sv
  - address_generation_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_address_generation.sv
